// ==== tagePkg.sv ====
`default_nettype none

package tagePkg;

    // pc and global history
    localparam int PcBits   = 32;
    localparam int HistBits = 32;

    // prediction counters
    localparam int CtrBits = 3;
    localparam logic [CtrBits-1:0] TakenThreshold = 3'd4;
    localparam logic [CtrBits-1:0] CtrReset       = 3'd4;

    // base table holds 128 entries
    localparam int BaseIdxBits = 7;

    // tagged tables, provider 0 is the base table
    localparam int NumTagged    = 3;
    localparam int ProviderBits = 2;

    // one table's read result
    typedef struct packed {
        logic               hit;
        logic [CtrBits-1:0] ctr;
    } tageReadT;

endpackage

`default_nettype wire

// ==== tageUpdateIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface tageUpdateIf;
    import tagePkg::*;

    logic                    Valid;
    logic [PcBits-1:0]       Pc;
    logic [HistBits-1:0]     History;
    logic [ProviderBits-1:0] Provider;
    logic [CtrBits-1:0]      Counter;

    modport source (
        output Valid,
        output Pc,
        output History,
        output Provider,
        output Counter
    );

    modport sink (
        input Valid,
        input Pc,
        input History,
        input Provider,
        input Counter
    );

endinterface

`default_nettype wire

// ==== tageHistory.sv ====
`timescale 1ns/1ps
`default_nettype none

module tageHistory (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic                         HistoryPush,
    input  logic                         HistoryTaken,
    input  logic                         HistoryRestore,
    input  logic [tagePkg::HistBits-1:0] HistoryRestoreValue,
    output logic [tagePkg::HistBits-1:0] History
);
    import tagePkg::*;

    logic [HistBits-1:0] historyNext;

    // restore wins over push
    always_comb begin
        historyNext = History;
        if (HistoryRestore) begin
            historyNext = HistoryRestoreValue;
        end else if (HistoryPush) begin
            // newest outcome enters at bit 0
            historyNext = {History[HistBits-2:0], HistoryTaken};
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            History <= '0;
        end else begin
            History <= historyNext;
        end
    end

endmodule

`default_nettype wire

// ==== tageBimodal.sv ====
`timescale 1ns/1ps
`default_nettype none

module tageBimodal (
    input  logic                       Clk,
    input  logic                       rst,
    input  logic                       Stall,
    input  logic                       Flush,
    input  logic                       LookupValid,
    input  logic [tagePkg::PcBits-1:0] LookupPc,
    tageUpdateIf.sink                  upd,
    output tagePkg::tageReadT          Read,
    output logic                       ReadValid
);
    import tagePkg::*;

    localparam int Depth = 1 << BaseIdxBits;

    logic [CtrBits-1:0]     ctrMem [Depth];
    logic [BaseIdxBits-1:0] lookupIdx;
    logic [BaseIdxBits-1:0] updIdx;
    logic [CtrBits-1:0]     rdCtr;
    logic                   readEn;
    logic                   writeEn;

    assign lookupIdx = LookupPc[BaseIdxBits+1:2];
    assign updIdx    = upd.Pc[BaseIdxBits+1:2];

    // any update owns the port, so a lookup in that cycle is lost
    assign readEn  = LookupValid && !Stall && !upd.Valid;
    assign writeEn = upd.Valid && !Stall && (upd.Provider == '0);

    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < Depth; i++) begin
                ctrMem[i] <= CtrReset;
            end
        end else if (writeEn) begin
            ctrMem[updIdx] <= upd.Counter;
        end
    end

    always_ff @(posedge Clk) begin
        if (readEn) begin
            rdCtr <= ctrMem[lookupIdx];
        end
    end

    // first-stage valid for the whole pipeline
    always_ff @(posedge Clk) begin
        if (rst) begin
            ReadValid <= 1'b0;
        end else if (!Stall) begin
            ReadValid <= LookupValid && !upd.Valid && !Flush;
        end
    end

    assign Read.hit = 1'b1;
    assign Read.ctr = rdCtr;

endmodule

`default_nettype wire

// ==== tageTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module tageTable #(
    parameter int IdxBits = 7,
    parameter int TagBits = 7,
    parameter int HistLen = 4,
    parameter int TableId = 1
) (
    input  logic                         Clk,
    input  logic                         rst,
    input  logic                         Stall,
    input  logic                         LookupValid,
    input  logic [tagePkg::PcBits-1:0]   LookupPc,
    input  logic [tagePkg::HistBits-1:0] History,
    tageUpdateIf.sink                    upd,
    output tagePkg::tageReadT            Read
);
    import tagePkg::*;

    localparam int Depth = 1 << IdxBits;

    logic [TagBits-1:0] tagMem [Depth];
    logic [CtrBits-1:0] ctrMem [Depth];
    logic [Depth-1:0]   validMem;

    logic [IdxBits-1:0] lookupIdx;
    logic [TagBits-1:0] lookupTag;
    logic [IdxBits-1:0] updIdx;
    logic [TagBits-1:0] updTag;
    logic               readEn;
    logic               writeEn;

    logic               rdValid;
    logic [TagBits-1:0] rdTag;
    logic [CtrBits-1:0] rdCtr;
    logic [TagBits-1:0] rdLookupTag;

    // xor of w-bit chunks, bit i lands on position i mod w
    function automatic logic [HistBits-1:0] foldHist(input logic [HistBits-1:0] hist,
                                                     input int w);
        logic [HistBits-1:0] res;
        res = '0;
        for (int i = 0; i < HistLen; i++) begin
            res[i % w] = res[i % w] ^ hist[i];
        end
        return res;
    endfunction

    function automatic logic [IdxBits-1:0] hashIdx(input logic [PcBits-1:0] pc,
                                                   input logic [HistBits-1:0] hist);
        logic [HistBits-1:0] f;
        f = foldHist(hist, IdxBits);
        return pc[IdxBits+1:2] ^ f[IdxBits-1:0];
    endfunction

    // tag bits sit just above the index field
    function automatic logic [TagBits-1:0] hashTag(input logic [PcBits-1:0] pc,
                                                   input logic [HistBits-1:0] hist);
        logic [HistBits-1:0] f;
        f = foldHist(hist, TagBits);
        return pc[IdxBits+2 +: TagBits] ^ f[TagBits-1:0];
    endfunction

    assign lookupIdx = hashIdx(LookupPc, History);
    assign lookupTag = hashTag(LookupPc, History);
    assign updIdx    = hashIdx(upd.Pc, upd.History);
    assign updTag    = hashTag(upd.Pc, upd.History);

    assign readEn  = LookupValid && !Stall && !upd.Valid;
    assign writeEn = upd.Valid && !Stall && (upd.Provider == ProviderBits'(TableId));

    always_ff @(posedge Clk) begin
        if (rst) begin
            validMem <= '0;
        end else if (writeEn) begin
            validMem[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            tagMem[updIdx] <= updTag;
            ctrMem[updIdx] <= upd.Counter;
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else if (readEn) begin
            rdValid <= validMem[lookupIdx];
        end
    end

    // entry and lookup tag travel together into stage two
    always_ff @(posedge Clk) begin
        if (readEn) begin
            rdTag       <= tagMem[lookupIdx];
            rdCtr       <= ctrMem[lookupIdx];
            rdLookupTag <= lookupTag;
        end
    end

    assign Read.hit = rdValid && (rdTag == rdLookupTag);
    assign Read.ctr = rdCtr;

endmodule

`default_nettype wire

// ==== tageProvider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tageProvider (
    input  logic                                           Clk,
    input  logic                                           rst,
    input  logic                                           Stall,
    input  logic                                           Flush,
    input  logic                                           ReadValid,
    input  tagePkg::tageReadT                              BaseRead,
    input  tagePkg::tageReadT [tagePkg::NumTagged-1:0]     TaggedRead,
    output logic                                           PredictValid,
    output logic                                           PredictTaken,
    output logic [tagePkg::CtrBits-1:0]                    PredictCounter,
    output logic [tagePkg::ProviderBits-1:0]               PredictProvider
);
    import tagePkg::*;

    tageReadT                selRead;
    logic [ProviderBits-1:0] selProvider;
    logic                    selTaken;
    logic                    loadEn;

    // longest history wins, later tables overwrite earlier hits
    always_comb begin
        selRead     = BaseRead;
        selProvider = '0;
        for (int i = 0; i < NumTagged; i++) begin
            if (TaggedRead[i].hit) begin
                selRead     = TaggedRead[i];
                selProvider = ProviderBits'(i + 1);
            end
        end
    end

    assign selTaken = selRead.ctr > TakenThreshold;
    assign loadEn   = ReadValid && !Flush;

    always_ff @(posedge Clk) begin
        if (rst) begin
            PredictValid <= 1'b0;
        end else if (!Stall) begin
            PredictValid <= loadEn;
        end
    end

    // result fields only move with a valid prediction
    always_ff @(posedge Clk) begin
        if (rst) begin
            PredictTaken    <= 1'b0;
            PredictCounter  <= '0;
            PredictProvider <= '0;
        end else if (!Stall && loadEn) begin
            PredictTaken    <= selTaken;
            PredictCounter  <= selRead.ctr;
            PredictProvider <= selProvider;
        end
    end

endmodule

`default_nettype wire

// ==== tagePredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagePredictor #(
    parameter int T1IdxBits = 7,
    parameter int T1TagBits = 7,
    parameter int T1HistLen = 4,
    parameter int T2IdxBits = 8,
    parameter int T2TagBits = 8,
    parameter int T2HistLen = 16,
    parameter int T3IdxBits = 7,
    parameter int T3TagBits = 9,
    parameter int T3HistLen = 32
) (
    input  logic                             Clk,
    input  logic                             rst,
    input  logic                             LookupValid,
    input  logic [tagePkg::PcBits-1:0]       LookupPc,
    input  logic                             HistoryPush,
    input  logic                             HistoryTaken,
    input  logic                             HistoryRestore,
    input  logic [tagePkg::HistBits-1:0]     HistoryRestoreValue,
    input  logic                             UpdateValid,
    input  logic [tagePkg::PcBits-1:0]       UpdatePc,
    input  logic [tagePkg::HistBits-1:0]     UpdateHistory,
    input  logic [tagePkg::ProviderBits-1:0] UpdateProvider,
    input  logic [tagePkg::CtrBits-1:0]      UpdateCounter,
    input  logic                             Stall,
    input  logic                             Flush,
    output logic                             PredictValid,
    output logic                             PredictTaken,
    output logic [tagePkg::CtrBits-1:0]      PredictCounter,
    output logic [tagePkg::ProviderBits-1:0] PredictProvider
);
    import tagePkg::*;

    logic [HistBits-1:0]            history;
    tageReadT                       baseRead;
    tageReadT [NumTagged-1:0]       taggedRead;
    logic                           readValid;

    // update bus, driven here and sunk by every table
    tageUpdateIf updBus ();

    assign updBus.Valid    = UpdateValid;
    assign updBus.Pc       = UpdatePc;
    assign updBus.History  = UpdateHistory;
    assign updBus.Provider = UpdateProvider;
    assign updBus.Counter  = UpdateCounter;

    tageHistory i_history (
        .Clk                 (Clk),
        .rst                 (rst),
        .HistoryPush         (HistoryPush),
        .HistoryTaken        (HistoryTaken),
        .HistoryRestore      (HistoryRestore),
        .HistoryRestoreValue (HistoryRestoreValue),
        .History             (history)
    );

    tageBimodal i_base (
        .Clk         (Clk),
        .rst         (rst),
        .Stall       (Stall),
        .Flush       (Flush),
        .LookupValid (LookupValid),
        .LookupPc    (LookupPc),
        .upd         (updBus),
        .Read        (baseRead),
        .ReadValid   (readValid)
    );

    tageTable #(
        .IdxBits (T1IdxBits),
        .TagBits (T1TagBits),
        .HistLen (T1HistLen),
        .TableId (1)
    ) i_t1 (
        .Clk         (Clk),
        .rst         (rst),
        .Stall       (Stall),
        .LookupValid (LookupValid),
        .LookupPc    (LookupPc),
        .History     (history),
        .upd         (updBus),
        .Read        (taggedRead[0])
    );

    tageTable #(
        .IdxBits (T2IdxBits),
        .TagBits (T2TagBits),
        .HistLen (T2HistLen),
        .TableId (2)
    ) i_t2 (
        .Clk         (Clk),
        .rst         (rst),
        .Stall       (Stall),
        .LookupValid (LookupValid),
        .LookupPc    (LookupPc),
        .History     (history),
        .upd         (updBus),
        .Read        (taggedRead[1])
    );

    tageTable #(
        .IdxBits (T3IdxBits),
        .TagBits (T3TagBits),
        .HistLen (T3HistLen),
        .TableId (3)
    ) i_t3 (
        .Clk         (Clk),
        .rst         (rst),
        .Stall       (Stall),
        .LookupValid (LookupValid),
        .LookupPc    (LookupPc),
        .History     (history),
        .upd         (updBus),
        .Read        (taggedRead[2])
    );

    tageProvider i_provider (
        .Clk             (Clk),
        .rst             (rst),
        .Stall           (Stall),
        .Flush           (Flush),
        .ReadValid       (readValid),
        .BaseRead        (baseRead),
        .TaggedRead      (taggedRead),
        .PredictValid    (PredictValid),
        .PredictTaken    (PredictTaken),
        .PredictCounter  (PredictCounter),
        .PredictProvider (PredictProvider)
    );

endmodule

`default_nettype wire

// ==== tagePredictor_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module tagePredictor_assert (
    input logic                             Clk,
    input logic                             rst,
    input logic                             LookupValid,
    input logic                             UpdateValid,
    input logic                             Stall,
    input logic                             Flush,
    input logic                             PredictValid,
    input logic                             PredictTaken,
    input logic [tagePkg::CtrBits-1:0]      PredictCounter,
    input logic [tagePkg::ProviderBits-1:0] PredictProvider
);

    // count of failed assertions
    int errCount = 0;

    // nothing comes out while reset is held
    resetQuiet: assert property (@(posedge Clk) rst |=> !PredictValid)
        else begin
            errCount = errCount + 1;
            $error("PredictValid high during reset");
        end

    // accepted lookup followed by a clean edge gives a prediction
    lookupToPredict: assert property (@(posedge Clk) disable iff (rst)
        (LookupValid && !UpdateValid && !Stall && !Flush) ##1 (!Stall && !Flush)
        |=> PredictValid)
        else begin
            errCount = errCount + 1;
            $error("accepted lookup produced no PredictValid");
        end

    // stall freezes every output
    holdOnStall: assert property (@(posedge Clk) disable iff (rst)
        Stall |=> $stable(PredictValid) && $stable(PredictTaken)
                  && $stable(PredictCounter) && $stable(PredictProvider))
        else begin
            errCount = errCount + 1;
            $error("outputs changed during stall");
        end

endmodule

`default_nettype wire

// ==== tb_tagePredictor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tagePredictor;
    import tagePkg::*;

    // stimulus runs about 1000 cycles
    localparam int TimeoutCycles = 4000;
    localparam int Rounds        = 120;
    localparam int MaxIdxBits    = 8;
    localparam int MaxTagBits    = 9;
    // T1, T2, T3 geometry
    localparam int IdxW [NumTagged]  = '{7, 8, 7};
    localparam int TagW [NumTagged]  = '{7, 8, 9};
    localparam int HistL [NumTagged] = '{4, 16, 32};

    typedef struct packed {
        logic                    taken;
        logic [CtrBits-1:0]      ctr;
        logic [ProviderBits-1:0] prov;
    } expT;

    // inputs for the next clock
    typedef struct packed {
        logic                    lookup;
        logic [PcBits-1:0]       pc;
        logic                    update;
        logic [PcBits-1:0]       updPc;
        logic [HistBits-1:0]     updHist;
        logic [ProviderBits-1:0] updProv;
        logic [CtrBits-1:0]      updCtr;
        logic                    push;
        logic                    taken;
        logic                    restore;
        logic [HistBits-1:0]     restoreVal;
        logic                    stall;
        logic                    flush;
    } stimT;

    logic                    Clk;
    logic                    rst;
    logic                    LookupValid;
    logic [PcBits-1:0]       LookupPc;
    logic                    HistoryPush;
    logic                    HistoryTaken;
    logic                    HistoryRestore;
    logic [HistBits-1:0]     HistoryRestoreValue;
    logic                    UpdateValid;
    logic [PcBits-1:0]       UpdatePc;
    logic [HistBits-1:0]     UpdateHistory;
    logic [ProviderBits-1:0] UpdateProvider;
    logic [CtrBits-1:0]      UpdateCounter;
    logic                    Stall;
    logic                    Flush;
    logic                    PredictValid;
    logic                    PredictTaken;
    logic [CtrBits-1:0]      PredictCounter;
    logic [ProviderBits-1:0] PredictProvider;

    stimT                    nx;
    logic [HistBits-1:0]     refHist;
    logic [CtrBits-1:0]      baseCtr [128];
    logic                    refValid [NumTagged][1 << MaxIdxBits];
    logic [MaxTagBits-1:0]   refTag [NumTagged][1 << MaxIdxBits];
    logic [CtrBits-1:0]      refCtr [NumTagged][1 << MaxIdxBits];
    logic                    s1Valid;
    expT                     s1Exp;
    expT                     expQ [$];
    logic                    stallAtEdge;
    int                      cycleCount = 0;

    tagePredictor i_tagePredictor (.*);

    bind tagePredictor tagePredictor_assert i_assert (.*);

    always #10 Clk = ~Clk;

    task automatic failRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            failRun($sformatf("MISMATCH at %0t: %s is %0d, expected %0d", $time, name, got, want));
        end
    endtask

    // n = 32 keeps every bit since that shift gives zero
    function automatic logic [31:0] lowBits(input logic [31:0] v, input int n);
        return v & ((32'd1 << n) - 32'd1);
    endfunction

    function automatic logic [31:0] foldHist(input logic [31:0] hist, input int len, input int w);
        logic [31:0] h;
        logic [31:0] res;
        h   = lowBits(hist, len);
        res = '0;
        for (int c = 0; c < len; c += w) begin
            res = res ^ lowBits(h >> c, w);
        end
        return res;
    endfunction

    function automatic logic [MaxIdxBits-1:0] tableIdx(input int t, input logic [31:0] pc,
                                                       input logic [31:0] hist);
        return MaxIdxBits'(lowBits(pc >> 2, IdxW[t]) ^ foldHist(hist, HistL[t], IdxW[t]));
    endfunction

    function automatic logic [MaxTagBits-1:0] tableTag(input int t, input logic [31:0] pc,
                                                       input logic [31:0] hist);
        return MaxTagBits'(lowBits(pc >> (IdxW[t] + 2), TagW[t])
                           ^ foldHist(hist, HistL[t], TagW[t]));
    endfunction

    // longest matching history provides the counter
    function automatic expT refPredict(input logic [PcBits-1:0] pc,
                                       input logic [HistBits-1:0] hist);
        expT                   res;
        logic [MaxIdxBits-1:0] idx;
        res.prov = '0;
        res.ctr  = baseCtr[pc[8:2]];
        for (int t = 0; t < NumTagged; t++) begin
            idx = tableIdx(t, pc, hist);
            if (refValid[t][idx] && refTag[t][idx] == tableTag(t, pc, hist)) begin
                res.ctr  = refCtr[t][idx];
                res.prov = ProviderBits'(t + 1);
            end
        end
        res.taken = res.ctr > TakenThreshold;
        return res;
    endfunction

    task automatic refWrite(input logic [PcBits-1:0] pc, input logic [HistBits-1:0] hist,
                            input logic [ProviderBits-1:0] prov, input logic [CtrBits-1:0] ctr);
        int                    t;
        logic [MaxIdxBits-1:0] idx;
        if (prov == '0) begin
            baseCtr[pc[8:2]] = ctr;
        end else begin
            t   = int'(prov) - 1;
            idx = tableIdx(t, pc, hist);
            refValid[t][idx] = 1'b1;
            refTag[t][idx]   = tableTag(t, pc, hist);
            refCtr[t][idx]   = ctr;
        end
    endtask

    // drive one clock of stimulus and move the model to what the DUT sees at the next edge
    task automatic step();
        expT lookupExp;
        @(posedge Clk);
        LookupValid         <= nx.lookup;
        LookupPc            <= nx.pc;
        HistoryPush         <= nx.push;
        HistoryTaken        <= nx.taken;
        HistoryRestore      <= nx.restore;
        HistoryRestoreValue <= nx.restoreVal;
        UpdateValid         <= nx.update;
        UpdatePc            <= nx.updPc;
        UpdateHistory       <= nx.updHist;
        UpdateProvider      <= nx.updProv;
        UpdateCounter       <= nx.updCtr;
        Stall               <= nx.stall;
        Flush               <= nx.flush;
        lookupExp = refPredict(nx.pc, refHist);
        if (!nx.stall) begin
            if (s1Valid && !nx.flush) begin
                expQ.push_back(s1Exp);
            end
            s1Valid = nx.lookup && !nx.update && !nx.flush;
            s1Exp   = lookupExp;
            if (nx.update) begin
                refWrite(nx.updPc, nx.updHist, nx.updProv, nx.updCtr);
            end
        end
        if (nx.restore) begin
            refHist = nx.restoreVal;
        end else if (nx.push) begin
            refHist = {refHist[HistBits-2:0], nx.taken};
        end
        nx = '0;
    endtask

    task automatic lookupAt(input logic [PcBits-1:0] pc);
        nx.lookup = 1'b1;
        nx.pc     = pc;
        step();
    endtask

    task automatic updateEntry(input logic [PcBits-1:0] pc, input logic [HistBits-1:0] hist,
                               input logic [ProviderBits-1:0] prov, input logic [CtrBits-1:0] ctr);
        nx.update  = 1'b1;
        nx.updPc   = pc;
        nx.updHist = hist;
        nx.updProv = prov;
        nx.updCtr  = ctr;
        step();
    endtask

    task automatic pushOutcome(input logic taken);
        nx.push  = 1'b1;
        nx.taken = taken;
        step();
    endtask

    task automatic restoreHistory(input logic [HistBits-1:0] value);
        nx.restore    = 1'b1;
        nx.restoreVal = value;
        step();
    endtask

    task automatic stallFor(input int n);
        repeat (n) begin
            nx.stall = 1'b1;
            step();
        end
    endtask

    always @(posedge Clk) begin
        stallAtEdge <= Stall;
        cycleCount  <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            failRun($sformatf("timeout, run still going after %0d cycles", TimeoutCycles));
        end
    end

    // a new prediction shows only after an unstalled edge
    always @(negedge Clk) begin : compare
        expT want;
        if (i_tagePredictor.i_assert.errCount != 0) begin
            failRun("a bound assertion on the DUT outputs failed");
        end else if (!rst && PredictValid === 1'b1 && !stallAtEdge) begin
            if (expQ.size() == 0) begin
                failRun("PredictValid seen with no lookup outstanding");
            end else begin
                want = expQ.pop_front();
                checkValue("PredictTaken", 32'(PredictTaken), 32'(want.taken));
                checkValue("PredictCounter", 32'(PredictCounter), 32'(want.ctr));
                checkValue("PredictProvider", 32'(PredictProvider), 32'(want.prov));
            end
        end
    end

    initial begin
        logic [PcBits-1:0] pc;
        logic [PcBits-1:0] basePc;
        void'($urandom(31137));
        Clk = 1'b0;
        rst = 1'b1;
        LookupValid = 1'b0;
        LookupPc = '0;
        HistoryPush = 1'b0;
        HistoryTaken = 1'b0;
        HistoryRestore = 1'b0;
        HistoryRestoreValue = '0;
        UpdateValid = 1'b0;
        UpdatePc = '0;
        UpdateHistory = '0;
        UpdateProvider = '0;
        UpdateCounter = '0;
        Stall = 1'b0;
        Flush = 1'b0;
        nx = '0;
        refHist = '0;
        s1Valid = 1'b0;
        for (int i = 0; i < 128; i++) begin
            baseCtr[i] = CtrReset;
        end
        for (int t = 0; t < NumTagged; t++) begin
            for (int i = 0; i < (1 << MaxIdxBits); i++) begin
                refValid[t][i] = 1'b0;
            end
        end
        repeat (16) @(posedge Clk);
        rst <= 1'b0;

        // back to back lookups on empty tables
        for (int i = 0; i < 8; i++) begin
            lookupAt($urandom());
        end

        // base counter write followed by a lookup that reads it
        basePc = $urandom();
        updateEntry(basePc, refHist, '0, 3'd6);
        lookupAt(basePc);

        // stalled write and stalled lookup take no effect
        lookupAt(basePc);
        lookupAt(basePc + 32'd4);
        nx.stall   = 1'b1;
        nx.lookup  = 1'b1;
        nx.pc      = basePc;
        nx.update  = 1'b1;
        nx.updPc   = basePc;
        nx.updProv = '0;
        nx.updCtr  = 3'd1;
        step();
        stallFor(2);
        lookupAt(basePc);

        // flush drops everything in flight and its own lookup
        lookupAt(basePc);
        lookupAt(basePc + 32'd8);
        nx.flush  = 1'b1;
        nx.lookup = 1'b1;
        nx.pc     = basePc;
        step();
        lookupAt(basePc);

        // lookup lost to an update in the same cycle
        nx.lookup  = 1'b1;
        nx.pc      = basePc;
        nx.update  = 1'b1;
        nx.updPc   = basePc + 32'd64;
        nx.updProv = '0;
        nx.updCtr  = 3'd7;
        step();
        lookupAt(basePc + 32'd64);

        for (int r = 0; r < Rounds; r++) begin
            restoreHistory($urandom());
            pc = $urandom();
            updateEntry(pc, refHist, ProviderBits'($urandom_range(3, 1)),
                        CtrBits'($urandom_range(7, 0)));
            if ($urandom_range(1, 0) == 1) begin
                updateEntry(pc, refHist, ProviderBits'($urandom_range(3, 0)),
                            CtrBits'($urandom_range(7, 0)));
            end
            lookupAt(pc);
            // flip one bit of the tag field region
            lookupAt(pc ^ (32'd1 << (9 + $urandom_range(6, 0))));
            // lookup sees the history from before this push
            nx.lookup = 1'b1;
            nx.pc     = pc;
            nx.push   = 1'b1;
            nx.taken  = 1'($urandom_range(1, 0));
            step();
            repeat ($urandom_range(3, 0)) begin
                pushOutcome(1'($urandom_range(1, 0)));
            end
            lookupAt(pc);
            if ($urandom_range(7, 0) == 0) begin
                stallFor(1 + $urandom_range(2, 0));
            end
        end

        while (s1Valid || expQ.size() != 0) begin
            step();
        end
        // idle a little longer to catch a stray prediction
        repeat (4) begin
            step();
        end
        @(negedge Clk);
        if (i_tagePredictor.i_assert.errCount != 0) begin
            failRun("a bound assertion on the DUT outputs failed");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== compile.f ====
tagePkg.sv
tageUpdateIf.sv
tageHistory.sv
tageBimodal.sv
tageTable.sv
tageProvider.sv
tagePredictor.sv
tagePredictor_assert.sv
tb_tagePredictor.sv

// ==== Bender.yml ====
package:
  name: tage_predictor

sources:
  - tagePkg.sv
  - tageUpdateIf.sv
  - tageHistory.sv
  - tageBimodal.sv
  - tageTable.sv
  - tageProvider.sv
  - tagePredictor.sv
  - target: test
    files:
      - tagePredictor_assert.sv
      - tb_tagePredictor.sv
